//--- Bender.yml
package:
  name: proc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/pipePkg.sv
      - hdl/fetch.sv
      - hdl/decode.sv
      - hdl/execute.sv
      - hdl/memory.sv
      - hdl/proc.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/procTb.sv

//--- hdl/core_consts.svh
/* Core constants
   Datapath, field and memory sizes shared by the pipelined core */

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath
`define DATA_W      16      // Register and memory word
`define REG_CNT     8       // General registers

// Instruction fields
`define INSTR_W     16
`define OPCODE_W    5       // Bits 15:11
`define FUNCT_W     2       // Register format, bits 1:0
`define IMM_W       5       // Signed imm5, bits 4:0

// Memories
`define IMEM_DEPTH  64      // Instruction words
`define DMEM_DEPTH  64      // Data words

`endif

//--- hdl/decode.sv
/* Decode stage
   Register file with write-through, immediate extension and ID/EX register */

`timescale 1ns/100ps
`include "core_consts.svh"

module decode import isaPkg::*, pipePkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  instr_t              instrIn,
    input  logic                regWriteIn,
    input  logic                memEnIn,
    input  logic                memWrIn,
    input  logic                aluImmIn,
    input  logic                haltIn,
    input  logic                wbEn,       // From memory stage
    input  regIdx_t             wbReg,
    input  word_t               wbData,
    output word_t               rsVal,
    output word_t               rtVal,      // Store data for ST
    output word_t               imm,
    output logic [`FUNCT_W-1:0] funct,
    output regIdx_t             dest,
    output logic                regWrite,
    output logic                memEn,
    output logic                memWr,
    output logic                aluImm,
    output logic                halt
);

    word_t   regs [`REG_CNT];
    regIdx_t rsIdx;
    regIdx_t rtIdx;
    word_t   rsRead;
    word_t   rtRead;
    word_t   immExt;

    assign rsIdx = instrIn[10:8];
    assign rtIdx = instrIn[7:5];     // Also immediate-format rd

    // Same-cycle writeback wins over the stored value
    assign rsRead = (wbEn && wbReg == rsIdx) ? wbData : regs[rsIdx];
    assign rtRead = (wbEn && wbReg == rtIdx) ? wbData : regs[rtIdx];

    assign immExt = {{(`DATA_W-`IMM_W){instrIn[`IMM_W-1]}}, instrIn[`IMM_W-1:0]};

    // Register file
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wbReg] <= wbData;
        end
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rsVal    <= '0;
            rtVal    <= '0;
            imm      <= '0;
            funct    <= '0;
            dest     <= '0;
            regWrite <= 1'b0;
            memEn    <= 1'b0;
            memWr    <= 1'b0;
            aluImm   <= 1'b0;
            halt     <= 1'b0;
        end else begin
            rsVal    <= rsRead;
            rtVal    <= rtRead;
            imm      <= immExt;
            funct    <= instrIn[`FUNCT_W-1:0];
            dest     <= aluImmIn ? instrIn[7:5] : instrIn[4:2];  // ADDI/LD vs rd
            regWrite <= regWriteIn;
            memEn    <= memEnIn;
            memWr    <= memWrIn;
            aluImm   <= aluImmIn;
            halt     <= haltIn;
        end
    end

endmodule

//--- hdl/execute.sv
/* Execute stage
   ALU with rt or immediate operand and the EX/MEM register */

`timescale 1ns/100ps
`include "core_consts.svh"

module execute import isaPkg::*, pipePkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  word_t               rsVal,
    input  word_t               rtVal,
    input  word_t               imm,        // Sign-extended imm5
    input  logic [`FUNCT_W-1:0] funct,
    input  regIdx_t             dest,
    input  logic                regWrite,
    input  logic                memEn,
    input  logic                memWr,
    input  logic                aluImm,
    input  logic                haltIn,
    output word_t               aluOut,     // Result or memory address
    output word_t               rtOut,
    output regIdx_t             destOut,
    output logic                regWriteOut,
    output logic                memEnOut,
    output logic                memWrOut,
    output logic                haltOut
);

    word_t  opB;
    aluOp_e op;
    word_t  result;

    assign opB = aluImm ? imm : rtVal;
    assign op  = aluImm ? ADD : aluOp_e'(funct);    // Immediate forms add

    always_comb begin
        case (op)
            ADD: result = rsVal + opB;
            SUB: result = rsVal - opB;
            AND: result = rsVal & opB;
            XOR: result = rsVal ^ opB;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluOut      <= '0;
            rtOut       <= '0;
            destOut     <= '0;
            regWriteOut <= 1'b0;
            memEnOut    <= 1'b0;
            memWrOut    <= 1'b0;
            haltOut     <= 1'b0;
        end else begin
            aluOut      <= result;
            rtOut       <= rtVal;
            destOut     <= dest;
            regWriteOut <= regWrite;
            memEnOut    <= memEn;
            memWrOut    <= memWr;
            haltOut     <= haltIn;
        end
    end

endmodule

//--- hdl/fetch.sv
/* Fetch stage
   Instruction memory with load responder, PC, control decode and IF/ID register */

`timescale 1ns/100ps
`include "core_consts.svh"

module fetch import isaPkg::*, pipePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      run,          // Core runs while high
    input  logic      loadReq,
    input  imemAddr_t loadAddr,
    input  instr_t    loadData,
    output logic      loadAck,
    output instr_t    instr,        // IF/ID instruction
    output imemAddr_t pc,           // Address of instr
    output logic      regWrite,
    output logic      memEn,
    output logic      memWr,
    output logic      aluImm,       // Immediate format
    output logic      halt,
    output logic      err           // Sticky illegal opcode
);

    localparam instr_t nopWord = {NOP, {(`INSTR_W-`OPCODE_W){1'b0}}};

    instr_t    imem [`IMEM_DEPTH];
    imemAddr_t pcReg;               // Next fetch address
    logic      frozen;              // Halt already issued
    logic      issue;
    hsState_e  loadState;
    instr_t    fetchWord;
    opcode_e   fetchOp;
    logic      decRegWrite;
    logic      decMemEn;
    logic      decMemWr;
    logic      decAluImm;
    logic      decHalt;
    logic      decIllegal;

    assign issue     = run && !frozen;
    assign fetchWord = imem[pcReg];
    assign fetchOp   = opcode_e'(fetchWord[`INSTR_W-1 -: `OPCODE_W]);

    // Control decode of the fetched word
    always_comb begin
        decRegWrite = 1'b0;
        decMemEn    = 1'b0;
        decMemWr    = 1'b0;
        decAluImm   = 1'b0;
        decHalt     = 1'b0;
        decIllegal  = 1'b0;
        case (fetchOp)
            RTYPE: decRegWrite = 1'b1;
            ADDI: begin
                decRegWrite = 1'b1;
                decAluImm   = 1'b1;
            end
            LD: begin
                decRegWrite = 1'b1;
                decMemEn    = 1'b1;
                decAluImm   = 1'b1;     // Address is rs + imm
            end
            ST: begin
                decMemEn    = 1'b1;
                decMemWr    = 1'b1;
                decAluImm   = 1'b1;
            end
            HALT:    decHalt = 1'b1;
            NOP:     ;                  // No control
            default: decIllegal = 1'b1; // Issues as a bubble
        endcase
    end

    // Instruction memory and load responder
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
            loadState <= IDLE;
            loadAck   <= 1'b0;
        end else begin
            case (loadState)
                IDLE: if (loadReq && !run) begin   // Ignored while running
                    imem[loadAddr] <= loadData;
                    loadAck        <= 1'b1;
                    loadState      <= ACK;
                end
                ACK: begin
                    if (loadReq) begin
                        loadState <= WAIT_DROP;
                    end else begin
                        loadAck   <= 1'b0;
                        loadState <= IDLE;
                    end
                end
                WAIT_DROP: if (!loadReq) begin
                    loadAck   <= 1'b0;
                    loadState <= IDLE;
                end
                default: loadState <= IDLE;
            endcase
        end
    end

    // PC and IF/ID register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcReg    <= '0;
            frozen   <= 1'b0;
            pc       <= '0;
            instr    <= '0;
            regWrite <= 1'b0;
            memEn    <= 1'b0;
            memWr    <= 1'b0;
            aluImm   <= 1'b0;
            halt     <= 1'b0;
            err      <= 1'b0;
        end else begin
            pc <= pcReg;
            if (!run) begin
                pcReg  <= '0;                   // Idle at zero
                frozen <= 1'b0;
            end else if (!frozen) begin
                pcReg  <= pcReg + 1'b1;
                frozen <= decHalt;              // Nothing after halt issues
            end
            if (issue) begin
                instr    <= fetchWord;
                regWrite <= decRegWrite;
                memEn    <= decMemEn;
                memWr    <= decMemWr;
                aluImm   <= decAluImm;
                halt     <= decHalt;
                err      <= err | decIllegal;
            end else begin
                instr    <= nopWord;
                regWrite <= 1'b0;
                memEn    <= 1'b0;
                memWr    <= 1'b0;
                aluImm   <= 1'b0;
                halt     <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/isaPkg.sv
/* ISA package
   Instruction word, opcode and ALU operation encodings */

`include "core_consts.svh"

package isaPkg;

    typedef logic [`INSTR_W-1:0] instr_t;    // Raw instruction word

    typedef enum logic [`OPCODE_W-1:0] {
        HALT  = 5'b00000,   // Also the reset value of memory
        NOP   = 5'b00001,
        ST    = 5'b10000,   // mem[rs + imm] = rt
        LD    = 5'b10001,   // rd = mem[rs + imm]
        ADDI  = 5'b01000,
        RTYPE = 5'b11011    // Operation from funct
    } opcode_e;

    typedef enum logic [`FUNCT_W-1:0] {
        ADD = 2'b00,
        SUB = 2'b01,        // rs - rt
        AND = 2'b10,
        XOR = 2'b11
    } aluOp_e;

    // Register format, rd in 4:2
    function automatic instr_t encR(aluOp_e op, logic [2:0] rd, logic [2:0] rs, logic [2:0] rt);
        return {RTYPE, rs, rt, rd, op};
    endfunction

    // Immediate format, rd or store source in 7:5
    function automatic instr_t encI(opcode_e op, logic [2:0] rd, logic [2:0] rs, logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

endpackage

//--- hdl/memory.sv
/* Memory stage
   Data memory with dump responder, writeback select, MEM/WB register and halt flag */

`timescale 1ns/100ps
`include "core_consts.svh"

module memory import pipePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  word_t     aluOut,       // Address or ALU result
    input  word_t     rtVal,        // Store data
    input  regIdx_t   dest,
    input  logic      regWrite,
    input  logic      memEn,
    input  logic      memWr,
    input  logic      haltIn,
    input  logic      dumpReq,
    input  dmemAddr_t dumpAddr,
    output word_t     dumpData,     // Valid while dumpAck high
    output logic      dumpAck,
    output logic      wbEn,
    output regIdx_t   wbReg,
    output word_t     wbData,
    output logic      halted        // Sticky
);

    word_t     dmem [`DMEM_DEPTH];
    dmemAddr_t addr;
    word_t     rdData;
    logic      isLoad;
    hsState_e  dumpState;

    assign addr   = aluOut[$bits(dmemAddr_t)-1:0];
    assign rdData = dmem[addr];
    assign isLoad = memEn && !memWr;

    // Data memory and dump responder
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
            dumpState <= IDLE;
            dumpAck   <= 1'b0;
            dumpData  <= '0;
        end else begin
            if (memEn && memWr) begin   // Store
                dmem[addr] <= rtVal;
            end
            case (dumpState)
                IDLE: if (dumpReq && halted) begin
                    dumpData  <= dmem[dumpAddr];
                    dumpAck   <= 1'b1;
                    dumpState <= ACK;
                end
                ACK: begin
                    if (dumpReq) begin
                        dumpState <= WAIT_DROP;
                    end else begin
                        dumpAck   <= 1'b0;
                        dumpState <= IDLE;
                    end
                end
                WAIT_DROP: if (!dumpReq) begin
                    dumpAck   <= 1'b0;
                    dumpState <= IDLE;
                end
                default: dumpState <= IDLE;
            endcase
        end
    end

    // MEM/WB register, writeback value chosen here
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbEn   <= 1'b0;
            wbReg  <= '0;
            wbData <= '0;
            halted <= 1'b0;
        end else begin
            wbEn   <= regWrite;
            wbReg  <= dest;
            wbData <= isLoad ? rdData : aluOut;
            halted <= halted | haltIn;    // Set as halt leaves this stage
        end
    end

endmodule

//--- hdl/pipePkg.sv
/* Pipeline package
   Datapath word types and the four-phase responder states */

`include "core_consts.svh"

package pipePkg;

    typedef logic [`DATA_W-1:0]             word_t;     // Register, ALU, memory value
    typedef logic [$clog2(`REG_CNT)-1:0]    regIdx_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr_t;
    typedef logic [$clog2(`DMEM_DEPTH)-1:0] dmemAddr_t; // Low bits of ALU result

    // Four-phase responder
    typedef enum logic [1:0] {
        IDLE      = 2'b00,  // Waiting for req
        ACK       = 2'b01,  // Ack just raised
        WAIT_DROP = 2'b10   // Ack held until req drops
    } hsState_e;

endpackage

//--- hdl/proc.sv
/* Processor top
   Five-stage 16-bit core, stages chained through their output registers */

`timescale 1ns/100ps
`include "core_consts.svh"

module proc import isaPkg::*, pipePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      run,
    input  logic      loadReq,      // Program load port
    input  imemAddr_t loadAddr,
    input  instr_t    loadData,
    output logic      loadAck,
    input  logic      dumpReq,      // Data dump port
    input  dmemAddr_t dumpAddr,
    output word_t     dumpData,
    output logic      dumpAck,
    output logic      halted,
    output logic      err
);

    // IF/ID
    instr_t idInstr;
    logic   idRegWrite, idMemEn, idMemWr, idAluImm, idHalt;

    // ID/EX
    word_t               exRsVal, exRtVal, exImm;
    logic [`FUNCT_W-1:0] exFunct;
    regIdx_t             exDest;
    logic                exRegWrite, exMemEn, exMemWr, exAluImm, exHalt;

    // EX/MEM
    word_t   memAluOut, memRtVal;
    regIdx_t memDest;
    logic    memRegWrite, memMemEn, memMemWr, memHalt;

    // Writeback, back into decode
    logic    wbEn;
    regIdx_t wbReg;
    word_t   wbData;

    fetch fetch0 (
        .clk(clk), .rstN(rstN), .run(run),
        .loadReq(loadReq), .loadAddr(loadAddr), .loadData(loadData), .loadAck(loadAck),
        .instr(idInstr), .pc(),     // PC unused without branches
        .regWrite(idRegWrite), .memEn(idMemEn), .memWr(idMemWr),
        .aluImm(idAluImm), .halt(idHalt), .err(err)
    );

    decode decode0 (
        .clk(clk), .rstN(rstN), .instrIn(idInstr),
        .regWriteIn(idRegWrite), .memEnIn(idMemEn), .memWrIn(idMemWr),
        .aluImmIn(idAluImm), .haltIn(idHalt),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .rsVal(exRsVal), .rtVal(exRtVal), .imm(exImm), .funct(exFunct), .dest(exDest),
        .regWrite(exRegWrite), .memEn(exMemEn), .memWr(exMemWr),
        .aluImm(exAluImm), .halt(exHalt)
    );

    execute execute0 (
        .clk(clk), .rstN(rstN),
        .rsVal(exRsVal), .rtVal(exRtVal), .imm(exImm), .funct(exFunct), .dest(exDest),
        .regWrite(exRegWrite), .memEn(exMemEn), .memWr(exMemWr),
        .aluImm(exAluImm), .haltIn(exHalt),
        .aluOut(memAluOut), .rtOut(memRtVal), .destOut(memDest),
        .regWriteOut(memRegWrite), .memEnOut(memMemEn), .memWrOut(memMemWr),
        .haltOut(memHalt)
    );

    memory memory0 (
        .clk(clk), .rstN(rstN),
        .aluOut(memAluOut), .rtVal(memRtVal), .dest(memDest),
        .regWrite(memRegWrite), .memEn(memMemEn), .memWr(memMemWr), .haltIn(memHalt),
        .dumpReq(dumpReq), .dumpAddr(dumpAddr), .dumpData(dumpData), .dumpAck(dumpAck),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted)
    );

endmodule

//--- list.f
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
tb/procTb.sv

//--- tb/procTb.sv
/* Processor testbench
   Loads programs, runs them to halt, dumps data memory against an ISA model */

`timescale 1ns/100ps
`include "core_consts.svh"

module procTb import isaPkg::*, pipePkg::*; ();

    localparam int hsTimeout   = 40;    // Cycles per handshake phase
    localparam int haltTimeout = 400;

    logic      clk;
    logic      rstN;
    logic      run;
    logic      loadReq;
    imemAddr_t loadAddr;
    instr_t    loadData;
    logic      loadAck;
    logic      dumpReq;
    dmemAddr_t dumpAddr;
    word_t     dumpData;
    logic      dumpAck;
    logic      halted;
    logic      err;

    instr_t prog [$];               // Program under test
    word_t  expMem [`DMEM_DEPTH];   // Model data memory
    logic   expErr;
    integer seed;
    string  curTest;
    int     failCount;
    int     startFails;             // failCount at test start
    int     testCount;
    int     failedTests;

    proc dut0 (
        .clk(clk), .rstN(rstN), .run(run),
        .loadReq(loadReq), .loadAddr(loadAddr), .loadData(loadData), .loadAck(loadAck),
        .dumpReq(dumpReq), .dumpAddr(dumpAddr), .dumpData(dumpData), .dumpAck(dumpAck),
        .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    // Four-phase rules on both ports
    ackLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !loadAck && !dumpAck)
        else noteError("an ack was high right after reset");
    loadAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(loadAck) |-> $past(loadReq))
        else noteError("loadAck rose with no load request");
    loadAckHolds: assert property (@(posedge clk) disable iff (!rstN)
        $fell(loadAck) |-> !$past(loadReq))
        else noteError("loadAck fell while the load request was still high");
    dumpAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(dumpAck) |-> $past(dumpReq))
        else noteError("dumpAck rose with no dump request");
    dumpAckHolds: assert property (@(posedge clk) disable iff (!rstN)
        $fell(dumpAck) |-> !$past(dumpReq))
        else noteError("dumpAck fell while the dump request was still high");
    dumpOnlyHalted: assert property (@(posedge clk) disable iff (!rstN) dumpAck |-> halted)
        else noteError("dumpAck high while the core was not halted");

    function automatic void noteError(input string msg);
        $display("%0s: %0s", curTest, msg);
        failCount++;
    endfunction

    function automatic int randGap();
        return $unsigned($random(seed)) % 4;    // 0..3 cycles between phases
    endfunction

    function automatic logic [4:0] randImm();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    // One cycle per step, inputs change 1 ns after the edge
    task automatic idleCycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Instruction plus two nops, so the next one may depend on it
    task automatic pushPadded(input instr_t word);
        prog.push_back(word);
        prog.push_back(encI(NOP, 3'd0, 3'd0, 5'd0));
        prog.push_back(encI(NOP, 3'd0, 3'd0, 5'd0));
    endtask

    task automatic resetCore();
        rstN    = 1'b0;
        run     = 1'b0;
        loadReq = 1'b0;
        dumpReq = 1'b0;
        idleCycles(3);
        rstN = 1'b1;
    endtask

    task automatic loadWord(input imemAddr_t addr, input instr_t word);
        int n;
        idleCycles(randGap());
        loadAddr = addr;
        loadData = word;
        loadReq  = 1'b1;
        n = 0;
        while (!loadAck && n < hsTimeout) begin
            idleCycles(1);
            n++;
        end
        if (!loadAck) noteError($sformatf("no loadAck for address %0d", addr));
        idleCycles(randGap());      // Hold req past the ack
        loadReq = 1'b0;
        n = 0;
        while (loadAck && n < hsTimeout) begin
            idleCycles(1);
            n++;
        end
        if (loadAck) noteError("loadAck stayed high after the request dropped");
    endtask

    task automatic dumpWord(input dmemAddr_t addr, output word_t data);
        int n;
        data = 'x;
        idleCycles(randGap());
        dumpAddr = addr;
        dumpReq  = 1'b1;
        n = 0;
        while (!dumpAck && n < hsTimeout) begin
            idleCycles(1);
            n++;
        end
        if (dumpAck) data = dumpData;   // Valid while ack is high
        else noteError($sformatf("no dumpAck for address %0d", addr));
        idleCycles(randGap());
        dumpReq = 1'b0;
        n = 0;
        while (dumpAck && n < hsTimeout) begin
            idleCycles(1);
            n++;
        end
        if (dumpAck) noteError("dumpAck stayed high after the request dropped");
    endtask

    // ISA-level model, one instruction at a time in program order
    task automatic runModel();
        word_t      regs [`REG_CNT];
        word_t      rsV;
        word_t      rtV;
        word_t      immV;
        word_t      ea;         // Effective address
        instr_t     w;
        logic [4:0] opc;
        int         pcM;
        int         i;
        logic       stop;
        for (i = 0; i < `REG_CNT; i++) regs[i] = '0;
        for (i = 0; i < `DMEM_DEPTH; i++) expMem[i] = '0;
        expErr = 1'b0;
        pcM    = 0;
        stop   = 1'b0;
        while (!stop && pcM < `IMEM_DEPTH) begin
            w    = (pcM < prog.size()) ? prog[pcM] : '0;   // Unloaded words read as halt
            opc  = w[15:11];
            rsV  = regs[w[10:8]];
            rtV  = regs[w[7:5]];
            immV = {{(`DATA_W-`IMM_W){w[4]}}, w[4:0]};
            ea   = rsV + immV;
            pcM++;
            case (opc)
                HALT:  stop = 1'b1;
                NOP:   ;
                ADDI:  regs[w[7:5]] = rsV + immV;
                LD:    regs[w[7:5]] = expMem[ea % `DMEM_DEPTH];
                ST:    expMem[ea % `DMEM_DEPTH] = rtV;
                RTYPE: begin
                    case (w[1:0])
                        2'b00: regs[w[4:2]] = rsV + rtV;
                        2'b01: regs[w[4:2]] = rsV - rtV;
                        2'b10: regs[w[4:2]] = rsV & rtV;
                        2'b11: regs[w[4:2]] = rsV ^ rtV;
                    endcase
                end
                default: expErr = 1'b1;  // No effect besides the flag
            endcase
        end
    endtask

    // Load, run to halt, then compare err and every data word
    task automatic runProgram();
        word_t got;
        int    i;
        int    n;
        for (i = 0; i < prog.size(); i++) begin
            loadWord(imemAddr_t'(i), prog[i]);
        end
        runModel();
        run = 1'b1;
        n   = 0;
        while (!halted && n < haltTimeout) begin
            idleCycles(1);
            n++;
        end
        if (!halted) begin
            noteError("halted never rose");
        end else begin
            assert (err === expErr) else begin
                $display("[FAIL] %0s err: expected %b, actual %b", curTest, expErr, err);
                failCount++;
            end
            for (i = 0; i < `DMEM_DEPTH; i++) begin
                dumpWord(dmemAddr_t'(i), got);
                assert (got === expMem[i]) else begin
                    $display("[FAIL] %0s mem[%0d]: expected %h, actual %h",
                             curTest, i, expMem[i], got);
                    failCount++;
                end
            end
        end
        run = 1'b0;
    endtask

    task automatic beginTest(input string name);
        curTest    = name;
        startFails = failCount;
        testCount++;
        prog.delete();
        resetCore();
    endtask

    task automatic endTest();
        if (failCount == startFails) begin
            $display("%-16s ok", curTest);
        end else begin
            $display("%-16s %0d error(s)", curTest, failCount - startFails);
            failedTests++;
        end
    endtask

    initial begin
        int   n;
        logic seenAck;
        seed        = 29341;
        failCount   = 0;
        testCount   = 0;
        failedTests = 0;
        curTest     = "init";
        rstN        = 1'b0;
        run         = 1'b0;
        loadReq     = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        dumpReq     = 1'b0;
        dumpAddr    = '0;

        // Dump port stays silent before halt
        beginTest("dumpBeforeHalt");
        dumpAddr = dmemAddr_t'($random(seed));
        dumpReq  = 1'b1;
        seenAck  = 1'b0;
        for (n = 0; n < hsTimeout; n++) begin
            idleCycles(1);
            seenAck = seenAck | dumpAck;
        end
        dumpReq = 1'b0;
        if (seenAck) noteError("dump request got an ack before halt");
        endTest();

        // Random operands through all four ALU ops
        beginTest("aluOps");
        pushPadded(encI(ADDI, 3'd1, 3'd0, randImm()));
        pushPadded(encI(ADDI, 3'd2, 3'd0, randImm()));
        pushPadded(encI(ADDI, 3'd1, 3'd1, randImm()));  // Chain onto r1
        pushPadded(encI(ADDI, 3'd2, 3'd2, randImm()));
        pushPadded(encR(ADD, 3'd1, 3'd1, 3'd1));         // Double r1
        pushPadded(encR(ADD, 3'd3, 3'd1, 3'd2));
        pushPadded(encR(SUB, 3'd4, 3'd1, 3'd2));
        pushPadded(encR(AND, 3'd5, 3'd1, 3'd2));
        pushPadded(encR(XOR, 3'd6, 3'd1, 3'd2));
        prog.push_back(encI(ST, 3'd3, 3'd0, 5'd1));
        prog.push_back(encI(ST, 3'd4, 3'd0, 5'd2));
        prog.push_back(encI(ST, 3'd5, 3'd0, 5'd3));
        prog.push_back(encI(ST, 3'd6, 3'd0, 5'd4));
        prog.push_back(encI(HALT, 3'd0, 3'd0, 5'd0));
        runProgram();
        endTest();

        // Negative imm5 must sign-extend
        beginTest("signExtend");
        pushPadded(encI(ADDI, 3'd1, 3'd0, randImm() | 5'b10000));
        pushPadded(encI(ADDI, 3'd2, 3'd1, 5'b10000));   // Another -16
        prog.push_back(encI(ST, 3'd1, 3'd0, 5'd6));
        prog.push_back(encI(ST, 3'd2, 3'd0, 5'd7));
        prog.push_back(encI(HALT, 3'd0, 3'd0, 5'd0));
        runProgram();
        endTest();

        // Store, load back, store again at a wrapped address
        beginTest("storeLoad");
        pushPadded(encI(ADDI, 3'd1, 3'd0, randImm()));
        pushPadded(encI(ADDI, 3'd2, 3'd0, randImm()));
        pushPadded(encR(SUB, 3'd3, 3'd1, 3'd2));
        prog.push_back(encI(ST, 3'd3, 3'd0, 5'd10));
        pushPadded(encI(LD, 3'd4, 3'd0, 5'd10));
        prog.push_back(encI(ST, 3'd4, 3'd0, 5'b11101));  // 0 - 3 wraps to 61
        prog.push_back(encI(HALT, 3'd0, 3'd0, 5'd0));
        runProgram();
        endTest();

        // Store behind halt never lands
        beginTest("haltThenStore");
        pushPadded(encI(ADDI, 3'd1, 3'd0, randImm() | 5'd1));
        prog.push_back(encI(ST, 3'd1, 3'd0, 5'd2));
        prog.push_back(encI(HALT, 3'd0, 3'd0, 5'd0));
        prog.push_back(encI(ST, 3'd1, 3'd0, 5'd3));
        runProgram();
        endTest();

        // Sticky err until reset
        beginTest("illegalOpcode");
        pushPadded(encI(ADDI, 3'd1, 3'd0, randImm()));
        prog.push_back({5'b11111, 11'h0});
        prog.push_back(encI(ST, 3'd1, 3'd0, 5'd4));
        prog.push_back(encI(HALT, 3'd0, 3'd0, 5'd0));
        runProgram();
        idleCycles(4);              // Core idle again
        assert (err === 1'b1) else begin
            $display("[FAIL] %0s err after run drop: expected 1, actual %b", curTest, err);
            failCount++;
        end
        resetCore();
        assert (err === 1'b0) else begin
            $display("[FAIL] %0s err after reset: expected 0, actual %b", curTest, err);
            failCount++;
        end
        endTest();

        $display("Tests: %0d, failing tests: %0d, failed checks: %0d",
                 testCount, failedTests, failCount);
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
